/* Makefile */
# Verilator build and run of the DMA controller testbench

VERILATOR ?= verilator
TOP       ?= tb_dmac_wrap
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) common/dmac_config.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* common/dmac_config.svh */
/*
 * Configuration macros of the cluster DMA controller
 * Port count, address, data and length widths, queue depths
 */

`ifndef DMAC_CONFIG_SVH
`define DMAC_CONFIG_SVH

// Number of requester control ports
`define DMAC_NB_CTRLS 3

// Scratchpad word address and data widths
`define DMAC_ADDR_WIDTH 12
`define DMAC_DATA_WIDTH 32

// Job length in words
`define DMAC_LEN_WIDTH 8

// Shared command queue depth
`define DMAC_CMD_DEPTH 4

// Read-ahead buffer depth and cap on reads in flight
`define DMAC_OUTSND 4

`endif

/* common/dmac_ctrl_pkg.sv */
/*
 * Control-side types of the DMA controller
 * Requester id, register offsets and the queued command record
 */

`include "dmac_config.svh"

package dmac_ctrl_pkg;

  // ******************************
  // Requester id
  // ******************************

  // Wide enough for all control ports
  typedef logic [1:0] id_t;

  // ******************************
  // Control register map
  // ******************************

  // Only the low three address bits select a register
  typedef enum logic [2:0] {
    REG_SRC    = 3'd0,
    REG_DST    = 3'd1,
    REG_LEN    = 3'd2,
    REG_START  = 3'd3,
    REG_STATUS = 3'd4
  } reg_offset_e;

  // One copy job as it sits in the command queue
  typedef struct packed {
    logic [`DMAC_ADDR_WIDTH-1:0] src;
    logic [`DMAC_ADDR_WIDTH-1:0] dst;
    logic [`DMAC_LEN_WIDTH-1:0]  len;
    id_t                         id;
  } cmd_t;

endpackage

/* common/dmac_mem_pkg.sv */
/*
 * Memory-side types of the DMA controller
 * Scratchpad word, word address and engine state
 */

`include "dmac_config.svh"

package dmac_mem_pkg;

  // One scratchpad data word
  typedef logic [`DMAC_DATA_WIDTH-1:0] word_t;

  // Word address into the scratchpad
  typedef logic [`DMAC_ADDR_WIDTH-1:0] addr_t;

  // Transfer engine states
  typedef enum logic {
    ENG_IDLE = 1'b0,
    ENG_RUN  = 1'b1
  } eng_state_e;

endpackage

/* ctrl/dmac_ctrl_unit.sv */
/*
 * Control unit of the DMA controller
 * Round-robin port arbiter, staged job registers per port,
 * command issue on START and STATUS readback with interrupt clear
 */

`timescale 1ns/1ps
`include "dmac_config.svh"

module dmac_ctrl_unit (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [`DMAC_NB_CTRLS-1:0]                        ctrl_req_i,
  input  logic [`DMAC_NB_CTRLS-1:0]                        ctrl_wen_i,
  input  logic [`DMAC_NB_CTRLS-1:0][`DMAC_ADDR_WIDTH-1:0]  ctrl_add_i,
  input  logic [`DMAC_NB_CTRLS-1:0][`DMAC_DATA_WIDTH-1:0]  ctrl_wdata_i,
  output logic [`DMAC_NB_CTRLS-1:0]                        ctrl_gnt_o,
  output logic [`DMAC_NB_CTRLS-1:0]                        ctrl_r_valid_o,
  output logic [`DMAC_NB_CTRLS-1:0][`DMAC_DATA_WIDTH-1:0]  ctrl_r_data_o,
  input  logic                                             cmd_full_i,
  output logic                                             cmd_push_o,
  output dmac_ctrl_pkg::cmd_t                              cmd_o,
  input  logic [`DMAC_NB_CTRLS-1:0]                        irq_i,
  output logic                                             status_clr_valid_o,
  output dmac_ctrl_pkg::id_t                               status_clr_id_o
);

  localparam int NB = `DMAC_NB_CTRLS;
  localparam int AW = `DMAC_ADDR_WIDTH;
  localparam int DW = `DMAC_DATA_WIDTH;

  // Staged job registers, one set per requester
  logic [AW-1:0]              src_q [NB];
  logic [AW-1:0]              dst_q [NB];
  logic [`DMAC_LEN_WIDTH-1:0] len_q [NB];

  logic [NB-1:0]             elig;
  logic                      gnt_any;
  dmac_ctrl_pkg::id_t        gnt_idx;
  dmac_ctrl_pkg::id_t        rr_q;
  dmac_ctrl_pkg::reg_offset_e sel_off;
  logic                      sel_rd;
  logic [DW-1:0]             rdata_d;
  logic [DW-1:0]             rdata_q;
  logic [NB-1:0]             r_valid_q;

  // ******************************
  // Round-robin arbiter
  // ******************************

  // A START write waits while the queue is full, so the turn moves on
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      elig[i] = ctrl_req_i[i] &&
                !(!ctrl_wen_i[i] && ctrl_add_i[i][2:0] == dmac_ctrl_pkg::REG_START &&
                  cmd_full_i);
    end
  end

  // Search starts at the port after the last winner
  always_comb begin
    gnt_any = 1'b0;
    gnt_idx = '0;
    for (int k = 0; k < NB; k++) begin
      if (!gnt_any && elig[(int'(rr_q) + k) % NB]) begin
        gnt_any = 1'b1;
        gnt_idx = dmac_ctrl_pkg::id_t'((int'(rr_q) + k) % NB);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      ctrl_gnt_o[i] = gnt_any && (gnt_idx == dmac_ctrl_pkg::id_t'(i));
    end
  end

  // Fields of the winning port
  assign sel_off = dmac_ctrl_pkg::reg_offset_e'(ctrl_add_i[gnt_idx][2:0]);
  assign sel_rd  = ctrl_wen_i[gnt_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (gnt_any) begin
      rr_q <= (gnt_idx == dmac_ctrl_pkg::id_t'(NB - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  // ******************************
  // Staged registers
  // ******************************

  always_ff @(posedge clk_i) begin
    if (gnt_any && !sel_rd) begin
      case (sel_off)
        dmac_ctrl_pkg::REG_SRC: src_q[gnt_idx] <= ctrl_wdata_i[gnt_idx][AW-1:0];
        dmac_ctrl_pkg::REG_DST: dst_q[gnt_idx] <= ctrl_wdata_i[gnt_idx][AW-1:0];
        dmac_ctrl_pkg::REG_LEN: len_q[gnt_idx] <= ctrl_wdata_i[gnt_idx][`DMAC_LEN_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // START with a zero length is acknowledged and dropped
  assign cmd_push_o = gnt_any && !sel_rd && sel_off == dmac_ctrl_pkg::REG_START &&
                      len_q[gnt_idx] != '0;

  always_comb begin
    cmd_o.src = src_q[gnt_idx];
    cmd_o.dst = dst_q[gnt_idx];
    cmd_o.len = len_q[gnt_idx];
    cmd_o.id  = gnt_idx;
  end

  // STATUS read drops the sticky interrupt of that port
  assign status_clr_valid_o = gnt_any && sel_rd && sel_off == dmac_ctrl_pkg::REG_STATUS;
  assign status_clr_id_o    = gnt_idx;

  // ******************************
  // Response path
  // ******************************

  // Writes answer with zero data
  always_comb begin
    rdata_d = '0;
    if (sel_rd) begin
      case (sel_off)
        dmac_ctrl_pkg::REG_SRC:    rdata_d = DW'(src_q[gnt_idx]);
        dmac_ctrl_pkg::REG_DST:    rdata_d = DW'(dst_q[gnt_idx]);
        dmac_ctrl_pkg::REG_LEN:    rdata_d = DW'(len_q[gnt_idx]);
        dmac_ctrl_pkg::REG_STATUS: rdata_d = DW'(irq_i[gnt_idx]);
        default:                   rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= '0;
    end else begin
      r_valid_q <= ctrl_gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_any) begin
      rdata_q <= rdata_d;
    end
  end

  // Data shows only on the port that owns the response
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      ctrl_r_data_o[i] = r_valid_q[i] ? rdata_q : '0;
    end
  end

  assign ctrl_r_valid_o = r_valid_q;

  // Single winner per cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(ctrl_gnt_o));

  // Queue back-pressure must hold off every command push
  assert property (@(posedge clk_i) disable iff (!rst_n_i) cmd_push_o |-> !cmd_full_i);

endmodule

/* engine/dmac_transfer_engine.sv */
/*
 * Transfer engine of the DMA controller
 * Takes one queued job, reads source words ahead into a buffer
 * and writes them to the destination over one scratchpad port
 */

`timescale 1ns/1ps
`include "dmac_config.svh"

module dmac_transfer_engine (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cmd_empty_i,
  input  dmac_ctrl_pkg::cmd_t cmd_i,
  output logic                cmd_pop_o,
  output logic                mem_req_o,
  output logic                mem_wen_o,
  output dmac_mem_pkg::addr_t mem_add_o,
  output dmac_mem_pkg::word_t mem_wdata_o,
  input  logic                mem_gnt_i,
  input  logic                mem_r_valid_i,
  input  dmac_mem_pkg::word_t mem_r_data_i,
  output logic                done_valid_o,
  output dmac_ctrl_pkg::id_t  done_id_o,
  output logic                active_o
);

  localparam int CW = $clog2(`DMAC_OUTSND + 1);

  dmac_mem_pkg::eng_state_e   state_q;
  dmac_mem_pkg::addr_t        src_q;
  dmac_mem_pkg::addr_t        dst_q;
  dmac_ctrl_pkg::id_t         id_q;
  logic [`DMAC_LEN_WIDTH-1:0] rd_left_q;
  logic [`DMAC_LEN_WIDTH-1:0] wr_left_q;
  logic [CW-1:0]              inflight_q;

  // Request held while waiting for a grant
  logic hold_q;
  logic hold_rd_q;

  logic                run;
  logic                rd_ok;
  logic                wr_sel;
  logic                rd_sel;
  logic                rd_gnt;
  logic                wr_gnt;
  logic                buf_empty;
  logic [CW-1:0]       buf_count;
  dmac_mem_pkg::word_t buf_head;
  logic                done_q;
  dmac_ctrl_pkg::id_t  done_id_q;

  // Read-ahead buffer filled by read responses
  dmac_fifo #(
    .T     ( dmac_mem_pkg::word_t ),
    .DEPTH ( `DMAC_OUTSND         )
  ) rd_buf_i (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .push_i  ( mem_r_valid_i ),
    .data_i  ( mem_r_data_i  ),
    .pop_i   ( wr_gnt        ),
    .data_o  ( buf_head      ),
    .full_o  (               ),
    .empty_o ( buf_empty     ),
    .count_o ( buf_count     )
  );

  assign run = (state_q == dmac_mem_pkg::ENG_RUN);

  // ******************************
  // Request selection
  // ******************************

  // Buffered words plus reads in flight never exceed the buffer
  assign rd_ok = (rd_left_q != '0) &&
                 ((int'(buf_count) + int'(inflight_q)) < `DMAC_OUTSND);

  // Buffer head writes win unless a read is already waiting
  assign wr_sel = run && (hold_q ? !hold_rd_q : !buf_empty);
  assign rd_sel = run && (hold_q ? hold_rd_q : (buf_empty && rd_ok));

  assign mem_req_o   = wr_sel || rd_sel;
  assign mem_wen_o   = rd_sel;
  assign mem_add_o   = wr_sel ? dst_q : src_q;
  assign mem_wdata_o = buf_head;

  assign rd_gnt = rd_sel && mem_gnt_i;
  assign wr_gnt = wr_sel && mem_gnt_i;

  // Next job is taken only from idle
  assign cmd_pop_o = !run && !cmd_empty_i;

  // ******************************
  // Job sequencing
  // ******************************

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= dmac_mem_pkg::ENG_IDLE;
      rd_left_q  <= '0;
      wr_left_q  <= '0;
      inflight_q <= '0;
      hold_q     <= 1'b0;
      hold_rd_q  <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      hold_q    <= mem_req_o && !mem_gnt_i;
      hold_rd_q <= rd_sel;
      done_q    <= wr_gnt && (wr_left_q == 1);
      // Response arrives one cycle after its grant
      if (rd_gnt && !mem_r_valid_i) begin
        inflight_q <= inflight_q + 1'b1;
      end else if (mem_r_valid_i && !rd_gnt) begin
        inflight_q <= inflight_q - 1'b1;
      end
      if (cmd_pop_o) begin
        state_q   <= dmac_mem_pkg::ENG_RUN;
        rd_left_q <= cmd_i.len;
        wr_left_q <= cmd_i.len;
      end else if (run) begin
        if (rd_gnt) begin
          rd_left_q <= rd_left_q - 1'b1;
        end
        if (wr_gnt) begin
          wr_left_q <= wr_left_q - 1'b1;
          // Last destination word ends the job
          if (wr_left_q == 1) begin
            state_q <= dmac_mem_pkg::ENG_IDLE;
          end
        end
      end
    end
  end

  // Address pointers and requester id
  always_ff @(posedge clk_i) begin
    if (cmd_pop_o) begin
      src_q <= cmd_i.src;
      dst_q <= cmd_i.dst;
      id_q  <= cmd_i.id;
    end else begin
      if (rd_gnt) begin
        src_q <= src_q + 1'b1;
      end
      if (wr_gnt) begin
        dst_q <= dst_q + 1'b1;
      end
    end
    if (wr_gnt) begin
      done_id_q <= id_q;
    end
  end

  assign done_valid_o = done_q;
  assign done_id_o    = done_id_q;

  // Covers the cycle between the last write and its report
  assign active_o = run || done_q;

  // Memory must not answer reads that were never granted
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_r_valid_i |-> inflight_q != '0);

endmodule

/* source/dmac_fifo.sv */
/*
 * Synchronous first-word fall-through FIFO
 * Payload type given as a parameter, circular buffer with counter
 */

`timescale 1ns/1ps

module dmac_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  T                           data_i,
  input  logic                       pop_i,
  output T                           data_o,
  output logic                       full_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                           mem_q [DEPTH];
  logic [PW-1:0]              wr_ptr_q;
  logic [PW-1:0]              rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] cnt_q;

  // Storage holds payload only
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Head word is visible without a pop
  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == ($clog2(DEPTH+1))'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign count_o = cnt_q;

  // Producers and consumers must honour the flags
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

/* source/dmac_term_unit.sv */
/*
 * Termination unit of the DMA controller
 * One-cycle events, sticky interrupts per port and busy flag
 */

`timescale 1ns/1ps
`include "dmac_config.svh"

module dmac_term_unit (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      done_valid_i,
  input  dmac_ctrl_pkg::id_t        done_id_i,
  input  logic                      status_clr_valid_i,
  input  dmac_ctrl_pkg::id_t        status_clr_id_i,
  input  logic                      active_i,
  input  logic                      cmd_empty_i,
  output logic [`DMAC_NB_CTRLS-1:0] term_event_o,
  output logic [`DMAC_NB_CTRLS-1:0] term_irq_o,
  output logic                      busy_o
);

  logic [`DMAC_NB_CTRLS-1:0] event_q;
  logic [`DMAC_NB_CTRLS-1:0] irq_q;
  logic                      busy_q;

  // ******************************
  // Events and interrupts
  // ******************************

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      event_q <= '0;
      irq_q   <= '0;
    end else begin
      for (int i = 0; i < `DMAC_NB_CTRLS; i++) begin
        event_q[i] <= done_valid_i && (done_id_i == dmac_ctrl_pkg::id_t'(i));
        // A new completion beats a clear on the same port
        if (done_valid_i && (done_id_i == dmac_ctrl_pkg::id_t'(i))) begin
          irq_q[i] <= 1'b1;
        end else if (status_clr_valid_i &&
                     (status_clr_id_i == dmac_ctrl_pkg::id_t'(i))) begin
          irq_q[i] <= 1'b0;
        end
      end
    end
  end

  // Work in the engine or waiting in the queue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= active_i || !cmd_empty_i;
    end
  end

  assign term_event_o = event_q;
  assign term_irq_o   = irq_q;
  assign busy_o       = busy_q;

endmodule

/* source/dmac_wrap.sv */
/*
 * Top level of the cluster DMA controller
 * Control unit, command queue, transfer engine, termination unit
 */

`timescale 1ns/1ps
`include "dmac_config.svh"

module dmac_wrap (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,

  // Requester control ports
  input  logic [`DMAC_NB_CTRLS-1:0]                        ctrl_req_i,
  input  logic [`DMAC_NB_CTRLS-1:0]                        ctrl_wen_i,
  input  logic [`DMAC_NB_CTRLS-1:0][`DMAC_ADDR_WIDTH-1:0]  ctrl_add_i,
  input  logic [`DMAC_NB_CTRLS-1:0][`DMAC_DATA_WIDTH-1:0]  ctrl_wdata_i,
  output logic [`DMAC_NB_CTRLS-1:0]                        ctrl_gnt_o,
  output logic [`DMAC_NB_CTRLS-1:0]                        ctrl_r_valid_o,
  output logic [`DMAC_NB_CTRLS-1:0][`DMAC_DATA_WIDTH-1:0]  ctrl_r_data_o,

  // Scratchpad initiator port
  output logic                                             mem_req_o,
  output logic                                             mem_wen_o,
  output dmac_mem_pkg::addr_t                              mem_add_o,
  output dmac_mem_pkg::word_t                              mem_wdata_o,
  input  logic                                             mem_gnt_i,
  input  logic                                             mem_r_valid_i,
  input  dmac_mem_pkg::word_t                              mem_r_data_i,

  // Job termination
  output logic [`DMAC_NB_CTRLS-1:0]                        term_event_o,
  output logic [`DMAC_NB_CTRLS-1:0]                        term_irq_o,
  output logic                                             busy_o
);

  // Control unit to command queue
  logic                 cmd_push;
  dmac_ctrl_pkg::cmd_t  cmd_in;
  logic                 cmd_full;

  // Command queue to engine
  logic                 cmd_pop;
  dmac_ctrl_pkg::cmd_t  cmd_out;
  logic                 cmd_empty;

  // Completion and status paths
  logic                 done_valid;
  dmac_ctrl_pkg::id_t   done_id;
  logic                 status_clr_valid;
  dmac_ctrl_pkg::id_t   status_clr_id;
  logic                 eng_active;

  // ******************************
  // Input side
  // ******************************

  dmac_ctrl_unit ctrl_unit_i (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .ctrl_req_i         ( ctrl_req_i       ),
    .ctrl_wen_i         ( ctrl_wen_i       ),
    .ctrl_add_i         ( ctrl_add_i       ),
    .ctrl_wdata_i       ( ctrl_wdata_i     ),
    .ctrl_gnt_o         ( ctrl_gnt_o       ),
    .ctrl_r_valid_o     ( ctrl_r_valid_o   ),
    .ctrl_r_data_o      ( ctrl_r_data_o    ),
    .cmd_full_i         ( cmd_full         ),
    .cmd_push_o         ( cmd_push         ),
    .cmd_o              ( cmd_in           ),
    .irq_i              ( term_irq_o       ),
    .status_clr_valid_o ( status_clr_valid ),
    .status_clr_id_o    ( status_clr_id    )
  );

  // ******************************
  // Processing
  // ******************************

  // Shared command queue, drained in order by the engine
  dmac_fifo #(
    .T     ( dmac_ctrl_pkg::cmd_t ),
    .DEPTH ( `DMAC_CMD_DEPTH      )
  ) cmd_fifo_i (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .push_i  ( cmd_push  ),
    .data_i  ( cmd_in    ),
    .pop_i   ( cmd_pop   ),
    .data_o  ( cmd_out   ),
    .full_o  ( cmd_full  ),
    .empty_o ( cmd_empty ),
    .count_o (           )
  );

  dmac_transfer_engine engine_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .cmd_empty_i   ( cmd_empty     ),
    .cmd_i         ( cmd_out       ),
    .cmd_pop_o     ( cmd_pop       ),
    .mem_req_o     ( mem_req_o     ),
    .mem_wen_o     ( mem_wen_o     ),
    .mem_add_o     ( mem_add_o     ),
    .mem_wdata_o   ( mem_wdata_o   ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .mem_r_data_i  ( mem_r_data_i  ),
    .done_valid_o  ( done_valid    ),
    .done_id_o     ( done_id       ),
    .active_o      ( eng_active    )
  );

  // Output side
  dmac_term_unit term_unit_i (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .done_valid_i       ( done_valid       ),
    .done_id_i          ( done_id          ),
    .status_clr_valid_i ( status_clr_valid ),
    .status_clr_id_i    ( status_clr_id    ),
    .active_i           ( eng_active       ),
    .cmd_empty_i        ( cmd_empty        ),
    .term_event_o       ( term_event_o     ),
    .term_irq_o         ( term_irq_o       ),
    .busy_o             ( busy_o           )
  );

endmodule

/* testbench/tb_dmac_wrap.sv */
/*
 * Testbench of the cluster DMA controller
 * Job table applied in loops, register readback, copies,
 * concurrent starts, interrupts, stalls and busy tracking
 */

`timescale 1ns/1ps
`include "dmac_config.svh"

module tb_dmac_wrap;

  localparam int NB = `DMAC_NB_CTRLS;
  localparam int WORDS = 1 << `DMAC_ADDR_WIDTH;
  localparam int LIMIT = 1000;

  typedef struct {
    int port;
    int src;
    int dst;
    int len;
    int status;
  } row_t;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic stall_en = 1'b0;
  logic [NB-1:0] ctrl_req = '0;
  logic [NB-1:0] ctrl_wen = '0;
  logic [NB-1:0][`DMAC_ADDR_WIDTH-1:0] ctrl_add = '0;
  logic [NB-1:0][`DMAC_DATA_WIDTH-1:0] ctrl_wdata = '0;
  logic [NB-1:0] ctrl_gnt, ctrl_r_valid, term_event, term_irq;
  logic [NB-1:0][`DMAC_DATA_WIDTH-1:0] ctrl_r_data;
  logic mem_req, mem_wen, mem_gnt, mem_r_valid, busy;
  logic [`DMAC_ADDR_WIDTH-1:0] mem_add;
  logic [`DMAC_DATA_WIDTH-1:0] mem_wdata, mem_r_data;

  row_t table_q [12];
  logic [31:0] exp_mem [WORDS];
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int ev_cnt [NB];
  int ev_total = 0;
  int pending = 0;
  int stg_len [NB];
  int ev_order [$];
  int start_order [$];
  logic [2:0] busy_hist = '0;

  always #4 clk = ~clk;

  dmac_wrap DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .ctrl_req_i (ctrl_req), .ctrl_wen_i (ctrl_wen), .ctrl_add_i (ctrl_add),
    .ctrl_wdata_i (ctrl_wdata), .ctrl_gnt_o (ctrl_gnt), .ctrl_r_valid_o (ctrl_r_valid),
    .ctrl_r_data_o (ctrl_r_data),
    .mem_req_o (mem_req), .mem_wen_o (mem_wen), .mem_add_o (mem_add),
    .mem_wdata_o (mem_wdata), .mem_gnt_i (mem_gnt), .mem_r_valid_i (mem_r_valid),
    .mem_r_data_i (mem_r_data),
    .term_event_o (term_event), .term_irq_o (term_irq), .busy_o (busy)
  );

  tb_tcdm_model tcdm (
    .clk_i (clk), .rst_n_i (rst_n), .stall_en_i (stall_en),
    .req_i (mem_req), .wen_i (mem_wen), .add_i (mem_add), .wdata_i (mem_wdata),
    .gnt_o (mem_gnt), .r_valid_o (mem_r_valid), .r_data_o (mem_r_data)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ******************************
  // Monitor sampled mid-cycle
  // ******************************

  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < NB; p++) begin
        if (term_event[p]) begin
          ev_cnt[p]++;
          ev_total++;
          pending--;
          ev_order.push_back(p);
        end
        if (ctrl_gnt[p] && !ctrl_wen[p] && ctrl_add[p][2:0] == 3'd2) begin
          stg_len[p] = int'(ctrl_wdata[p][`DMAC_LEN_WIDTH-1:0]);
        end
        if (ctrl_gnt[p] && !ctrl_wen[p] && ctrl_add[p][2:0] == 3'd3 && stg_len[p] != 0) begin
          start_order.push_back(p);
          pending++;
        end
      end
      // Busy has two cycles to follow a queued job
      busy_hist = {busy_hist[1:0], pending > 0};
      if (busy_hist == 3'b111 && !busy) begin
        check("busy_o", busy, 1'b1);
      end
    end
  end

  // ******************************
  // Control port access
  // ******************************

  // Starts and ends 1 ns after a rising edge
  task automatic ctrl_access(input int p, input bit rd, input int off,
                             input logic [31:0] wd, output logic [31:0] rdata);
    int n;
    n = 0;
    rdata = '0;
    ctrl_req[p] = 1'b1;
    ctrl_wen[p] = rd;
    ctrl_add[p] = off;
    ctrl_wdata[p] = wd;
    @(negedge clk);
    while (!ctrl_gnt[p] && n < LIMIT) begin
      n++;
      @(negedge clk);
    end
    @(posedge clk);
    #1 ctrl_req[p] = 1'b0;
    if (n >= LIMIT) begin
      errors++;
      $display("timeout: port %0d was never granted", p);
    end else begin
      @(negedge clk);
      check($sformatf("ctrl_r_valid_o[%0d]", p), ctrl_r_valid[p], 1'b1);
      rdata = ctrl_r_data[p];
      // Write responses carry no data
      if (!rd) begin
        check($sformatf("ctrl_r_data_o[%0d]", p), rdata, '0);
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic program_row(input int i, input bit readback);
    logic [31:0] d;
    ctrl_access(table_q[i].port, 0, 0, table_q[i].src, d);
    ctrl_access(table_q[i].port, 0, 1, table_q[i].dst, d);
    ctrl_access(table_q[i].port, 0, 2, table_q[i].len, d);
    if (readback) begin
      ctrl_access(table_q[i].port, 1, 0, 0, d);
      check("SRC readback", d, table_q[i].src);
      ctrl_access(table_q[i].port, 1, 1, 0, d);
      check("DST readback", d, table_q[i].dst);
      ctrl_access(table_q[i].port, 1, 2, 0, d);
      check("LEN readback", d, table_q[i].len);
    end
  endtask

  // Shadow copy follows the job
  // Source and destination ranges never overlap
  task automatic start_row(input int i);
    logic [31:0] d;
    for (int k = 0; k < table_q[i].len; k++) begin
      exp_mem[table_q[i].dst + k] = exp_mem[table_q[i].src + k];
    end
    ctrl_access(table_q[i].port, 0, 3, 0, d);
  endtask

  task automatic wait_events(input int target);
    int n;
    n = 0;
    while (ev_total < target && n < LIMIT * 4) begin
      n++;
      @(posedge clk);
      #1;
    end
    if (n >= LIMIT * 4) begin
      errors++;
      $display("timeout: only %0d of %0d termination events seen", ev_total, target);
    end
  endtask

  task automatic compare_memory();
    for (int a = 0; a < WORDS; a++) begin
      if (tcdm.mem_q[a] !== exp_mem[a]) begin
        check($sformatf("mem[%03h]", a), tcdm.mem_q[a], exp_mem[a]);
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %s: %0d errors", name, errors - err_before);
  endtask

  initial begin
    int e0;
    int base;
    logic [31:0] d;
    void'($urandom(10));
    for (int a = 0; a < WORDS; a++) begin
      exp_mem[a] = 32'hD0A0_0000 + a;
    end
    for (int p = 0; p < NB; p++) begin
      ev_cnt[p] = 0;
      stg_len[p] = 0;
    end
    // Port, source, destination, length, expected status
    table_q[0] = '{0, 'h010, 'h400, 5, 1};
    table_q[1] = '{1, 'h020, 'h410, 8, 1};
    table_q[2] = '{2, 'h030, 'h420, 3, 1};
    table_q[3] = '{0, 'h040, 'h500, 6, 1};
    table_q[4] = '{1, 'h050, 'h510, 4, 1};
    table_q[5] = '{2, 'h060, 'h520, 7, 1};
    table_q[6] = '{0, 'h100, 'h600, 12, 1};
    table_q[7] = '{1, 'h120, 'h620, 9, 1};
    table_q[8] = '{2, 'h140, 'h640, 16, 1};
    table_q[9] = '{0, 'h160, 'h660, 5, 1};
    table_q[10] = '{1, 'h180, 'h680, 10, 1};
    table_q[11] = '{2, 'h1A0, 'h6A0, 0, 0};

    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    e0 = errors;
    check("ctrl_gnt_o", ctrl_gnt, '0);
    check("ctrl_r_valid_o", ctrl_r_valid, '0);
    check("mem_req_o", mem_req, 1'b0);
    check("term_event_o", term_event, '0);
    check("term_irq_o", term_irq, '0);
    check("busy_o", busy, 1'b0);
    @(posedge clk);
    #1;
    report_test("reset", e0);

    // Readback, single copy and interrupt per row
    for (int i = 0; i < 3; i++) begin
      e0 = errors;
      program_row(i, 1);
      base = ev_cnt[table_q[i].port];
      start_row(i);
      wait_events(ev_total + 1);
      check("term_event_o count", ev_cnt[table_q[i].port], base + 1);
      compare_memory();
      repeat (3) @(posedge clk);
      #1;
      check("term_irq_o", term_irq[table_q[i].port], 1'b1);
      ctrl_access(table_q[i].port, 1, 4, 0, d);
      check("STATUS", d, table_q[i].status);
      check("term_irq_o", term_irq[table_q[i].port], 1'b0);
      ctrl_access(table_q[i].port, 1, 4, 0, d);
      check("STATUS", d, 0);
      report_test($sformatf("single copy port %0d", table_q[i].port), e0);
    end

    // Three STARTs in one cycle
    e0 = errors;
    ev_order.delete();
    start_order.delete();
    base = ev_total;
    for (int i = 3; i < 6; i++) begin
      program_row(i, 0);
    end
    fork
      start_row(3);
      start_row(4);
      start_row(5);
    join
    wait_events(base + 3);
    repeat (5) @(posedge clk);
    #1;
    check("event count", ev_total, base + 3);
    for (int p = 0; p < NB; p++) begin
      check($sformatf("event order %0d", p), ev_order[p], start_order[p]);
    end
    compare_memory();
    report_test("concurrent jobs", e0);

    // Grant stalls, full queue and a zero-length job
    e0 = errors;
    stall_en = 1'b1;
    base = ev_total;
    // All ports staged first, then started back to back
    for (int i = 6; i < 9; i++) begin
      program_row(i, 0);
    end
    for (int i = 6; i < 9; i++) begin
      start_row(i);
    end
    // Later STARTs land on a queue held up by the first long job
    for (int i = 9; i < 12; i++) begin
      program_row(i, 0);
      start_row(i);
    end
    wait_events(base + 5);
    repeat (30) @(posedge clk);
    #1;
    check("event count", ev_total, base + 5);
    check("busy_o", busy, 1'b0);
    compare_memory();
    report_test("stalls and back-pressure", e0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* testbench/tb_tcdm_model.sv */
/*
 * Scratchpad memory model for the DMA testbench
 * Word memory with address-based preload, random grant stalls,
 * read data one cycle after grant
 */

`timescale 1ns/1ps
`include "dmac_config.svh"

module tb_tcdm_model (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        stall_en_i,
  input  logic                        req_i,
  input  logic                        wen_i,
  input  logic [`DMAC_ADDR_WIDTH-1:0] add_i,
  input  logic [`DMAC_DATA_WIDTH-1:0] wdata_i,
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output logic [`DMAC_DATA_WIDTH-1:0] r_data_o
);

  localparam int WORDS = 1 << `DMAC_ADDR_WIDTH;

  logic [`DMAC_DATA_WIDTH-1:0] mem_q [WORDS];
  logic                        stall_q;

  // Preload with address plus a constant
  initial begin
    for (int a = 0; a < WORDS; a++) begin
      mem_q[a] = 32'hD0A0_0000 + a;
    end
  end

  // Grant withheld on a random stall cycle
  assign gnt_o = req_i && !(stall_en_i && stall_q);

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      stall_q   <= 1'b0;
      r_valid_o <= 1'b0;
      r_data_o  <= '0;
    end else begin
      stall_q   <= ($urandom % 2) == 1;
      r_valid_o <= req_i && gnt_o && wen_i;
      // wen high means read
      if (req_i && gnt_o && wen_i) begin
        r_data_o <= mem_q[add_i];
      end
      if (req_i && gnt_o && !wen_i) begin
        mem_q[add_i] <= wdata_i;
      end
    end
  end

endmodule

/* verilog.f */
+incdir+common
common/dmac_ctrl_pkg.sv
common/dmac_mem_pkg.sv
source/dmac_fifo.sv
ctrl/dmac_ctrl_unit.sv
engine/dmac_transfer_engine.sv
source/dmac_term_unit.sv
source/dmac_wrap.sv
testbench/tb_tcdm_model.sv
testbench/tb_dmac_wrap.sv
